// ==== design/alu16.sv ====
// 16-bit ALU with add, subtract, and, nor, shifts and flag generation
`timescale 1ns/100ps
`default_nettype none

module alu16 (
    input  wire [15:0]                a,
    input  wire [15:0]                b,
    input  wire [3:0]                 shamt,
    input  wire exec_core_pkg::opcode_e op,
    output logic [15:0]               result,
    output exec_core_pkg::flags_t     flags
);
    import exec_core_pkg::*;

    logic ovf;                              // Signed overflow of add/sub

    always_comb begin
        result = '0;
        ovf    = 1'b0;
        case (op)
            OP_ADD, OP_ADDI: begin
                result = a + b;             // Wraps at 16 bits
                ovf    = (a[15] == b[15]) && (result[15] != a[15]);
            end
            OP_SUB: begin
                result = a - b;
                ovf    = (a[15] != b[15]) && (result[15] != a[15]);
            end
            OP_AND: result = a & b;
            OP_NOR: result = ~(a | b);
            OP_SLL: result = a << shamt;
            OP_SRL: result = a >> shamt;    // Zero fill
            OP_SRA: result = 16'($signed(a) >>> shamt);   // Sign fill
            default: result = '0;
        endcase
    end

    // v only from add/sub, cleared otherwise
    assign flags = '{z: (result == 16'd0), v: ovf, n: result[15]};

endmodule

`default_nettype wire

// ==== design/ex_unit.sv ====
// Execute stage: operand select, load half merge, flags, branch and the execute register
`timescale 1ns/100ps
`default_nettype none

module ex_unit (
    input  wire                         clk,
    input  wire                         rst,
    input  wire exec_core_pkg::dec_op_t dec_op,
    output exec_core_pkg::ex_res_t      ex_res,
    output logic                        redirect_valid,
    output exec_core_pkg::redirect_t    redirect
);
    import exec_core_pkg::*;

    logic [15:0] alu_b;
    logic [15:0] alu_out;
    logic [15:0] result;
    flags_t      alu_flags;
    logic        set_en;
    ex_res_t     nxt_res;

    //////////////////////////////////////////////////
    // ALU and operand select
    //////////////////////////////////////////////////
    assign alu_b = dec_op.use_imm ? dec_op.imm : dec_op.src_b;   // ADDI takes imm

    alu16 u_alu (
        .a      (dec_op.src_a),
        .b      (alu_b),
        .shamt  (dec_op.imm[3:0]),          // Shift amount sits in the low imm bits
        .op     (dec_op.op),
        .result (alu_out),
        .flags  (alu_flags)
    );

    // Load half replaces one byte of the old rd
    always_comb begin
        case (dec_op.op)
            OP_LHB:        result = {dec_op.half_imm, dec_op.src_b[7:0]};
            OP_LLB:        result = {dec_op.src_b[15:8], dec_op.half_imm};
            OP_BR, OP_NOP: result = '0;     // Nothing to write
            default:       result = alu_out;
        endcase
    end

    // Only real ALU ops touch the flags
    assign set_en = dec_op.valid &&
                    (dec_op.op inside {OP_ADD, OP_SUB, OP_AND, OP_NOR,
                                       OP_SLL, OP_SRL, OP_SRA, OP_ADDI});

    flag_branch_unit u_flag_branch (
        .clk            (clk),
        .rst            (rst),
        .set_en         (set_en),
        .new_flags      (alu_flags),
        .is_branch      (dec_op.valid && dec_op.op == OP_BR),
        .cond           (dec_op.cond),
        .pc             (dec_op.pc),
        .offset         (dec_op.imm),
        .redirect_valid (redirect_valid),
        .redirect       (redirect)
    );

    //////////////////////////////////////////////////
    // Execute pipeline register
    //////////////////////////////////////////////////
    always_comb begin
        nxt_res.valid = dec_op.valid;
        nxt_res.wr_en = dec_op.valid && dec_op.wr_en;   // Scoreboard reads this directly
        nxt_res.dest  = dec_op.dest;
        nxt_res.data  = result;
    end

    always_ff @(posedge clk) begin
        ex_res <= nxt_res;
        if (rst) begin
            ex_res.valid <= 1'b0;
            ex_res.wr_en <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/exec_core.sv ====
// Execute core top with the decode, execute and result stages
`timescale 1ns/100ps
`default_nettype none

module exec_core #(
    parameter int QUEUE_DEPTH = 4           // Credits the source starts with
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             in_valid,
    input  wire exec_core_pkg::fetch_word_t in_word,
    output logic                            credit_return,
    output logic                            retire_valid,
    output exec_core_pkg::retire_t          retire,
    output logic                            redirect_valid,
    output exec_core_pkg::redirect_t        redirect
);
    import exec_core_pkg::*;

    dec_op_t     dec_op;
    ex_res_t     ex_res;
    logic [3:0]  rd_addr_a;
    logic [3:0]  rd_addr_b;
    logic [15:0] rd_data_a;
    logic [15:0] rd_data_b;
    logic [3:0]  ex_dest;
    logic        ex_wr;

    // Execute register seen by the scoreboard
    assign ex_dest = ex_res.dest;
    assign ex_wr   = ex_res.wr_en;

    instr_decode #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_decode (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_word       (in_word),
        .rd_data_a     (rd_data_a),
        .rd_data_b     (rd_data_b),
        .ex_dest       (ex_dest),
        .ex_wr         (ex_wr),
        .credit_return (credit_return),
        .rd_addr_a     (rd_addr_a),
        .rd_addr_b     (rd_addr_b),
        .dec_op        (dec_op)
    );

    ex_unit u_ex (
        .clk            (clk),
        .rst            (rst),
        .dec_op         (dec_op),
        .ex_res         (ex_res),
        .redirect_valid (redirect_valid),
        .redirect       (redirect)
    );

    result_stage u_result (
        .clk          (clk),
        .rst          (rst),
        .ex_res       (ex_res),
        .pc_in        (dec_op.pc),          // Delayed inside to match ex_res
        .rd_addr_a    (rd_addr_a),
        .rd_addr_b    (rd_addr_b),
        .rd_data_a    (rd_data_a),
        .rd_data_b    (rd_data_b),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

`default_nettype wire

// ==== design/exec_core_pkg.sv ====
// Opcode and branch-condition enums, field widths and the stage records of the execute core
`default_nettype none

package exec_core_pkg;

    //////////////////////////////////////////////////
    // Widths and sizes
    //////////////////////////////////////////////////
    localparam int REG_W   = 16;            // Datapath width
    localparam int REG_CNT = 16;            // Register file entries

    // Opcodes in instr[15:12], anything else runs as NOP
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_NOR  = 4'h3,
        OP_SLL  = 4'h4,
        OP_SRL  = 4'h5,
        OP_SRA  = 4'h6,
        OP_ADDI = 4'h7,
        OP_LHB  = 4'h8,
        OP_LLB  = 4'h9,
        OP_BR   = 4'hA,
        OP_NOP  = 4'hF
    } opcode_e;

    // Branch condition in instr[11:9]
    typedef enum logic [2:0] {
        BC_NE = 3'd0,
        BC_EQ = 3'd1,
        BC_GT = 3'd2,
        BC_LT = 3'd3,
        BC_GE = 3'd4,
        BC_LE = 3'd5,
        BC_OV = 3'd6,
        BC_UN = 3'd7                        // Always taken
    } branch_cond_e;

    //////////////////////////////////////////////////
    // Stage records
    //////////////////////////////////////////////////
    typedef struct packed {
        logic [15:0] pc;
        logic [15:0] instr;
    } fetch_word_t;

    typedef struct packed {
        logic             valid;
        opcode_e          op;
        branch_cond_e     cond;
        logic [3:0]       dest;
        logic             wr_en;
        logic [REG_W-1:0] src_a;            // rs value
        logic [REG_W-1:0] src_b;            // rt value, or rd for load half
        logic [REG_W-1:0] imm;              // Sign extended, BR offset or 4-bit imm
        logic             use_imm;          // ALU operand b from imm
        logic [7:0]       half_imm;         // LHB/LLB byte
        logic [15:0]      pc;
    } dec_op_t;

    typedef struct packed {
        logic             valid;
        logic             wr_en;            // Only set together with valid
        logic [3:0]       dest;
        logic [REG_W-1:0] data;
    } ex_res_t;

    typedef struct packed {
        logic [3:0]       dest;
        logic [REG_W-1:0] data;
        logic             wr_en;
        logic [15:0]      pc;
    } retire_t;

    typedef struct packed {
        logic        taken;
        logic [15:0] target;
    } redirect_t;

    typedef struct packed {
        logic z;                            // Zero
        logic v;                            // Signed overflow
        logic n;                            // Negative
    } flags_t;

endpackage

`default_nettype wire

// ==== design/flag_branch_unit.sv ====
// Flag register and branch condition check with the registered redirect record
`timescale 1ns/100ps
`default_nettype none

module flag_branch_unit (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              set_en,
    input  wire exec_core_pkg::flags_t       new_flags,
    input  wire                              is_branch,
    input  wire exec_core_pkg::branch_cond_e cond,
    input  wire [15:0]                       pc,
    input  wire [15:0]                       offset,
    output logic                             redirect_valid,
    output exec_core_pkg::redirect_t         redirect
);
    import exec_core_pkg::*;

    flags_t flags_q;                        // Flags of the last ALU op
    logic   taken;

    always_comb begin
        case (cond)
            BC_NE:   taken = !flags_q.z;
            BC_EQ:   taken = flags_q.z;
            BC_GT:   taken = !flags_q.z && !flags_q.n;
            BC_LT:   taken = flags_q.n;
            BC_GE:   taken = !flags_q.n;
            BC_LE:   taken = flags_q.z || flags_q.n;
            BC_OV:   taken = flags_q.v;
            default: taken = 1'b1;          // UN
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flags_q        <= '0;
            redirect_valid <= 1'b0;
        end else begin
            if (set_en)
                flags_q <= new_flags;
            redirect_valid <= is_branch;
        end
    end

    // Target reported whether taken or not
    always_ff @(posedge clk) begin
        redirect.taken  <= taken;
        redirect.target <= pc + 16'd1 + offset;
    end

endmodule

`default_nettype wire

// ==== design/instr_decode.sv ====
// Decode stage: credit queue, field split, hazard stall and register reads
`timescale 1ns/100ps
`default_nettype none

module instr_decode #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         in_valid,
    input  wire exec_core_pkg::fetch_word_t in_word,
    input  wire [15:0]                  rd_data_a,
    input  wire [15:0]                  rd_data_b,
    input  wire [3:0]                   ex_dest,
    input  wire                         ex_wr,
    output logic                        credit_return,
    output logic [3:0]                  rd_addr_a,
    output logic [3:0]                  rd_addr_b,
    output exec_core_pkg::dec_op_t      dec_op
);
    import exec_core_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    fetch_word_t      queue [QUEUE_DEPTH];  // Entries owed to the source's credits
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    fetch_word_t      head;
    opcode_e          op;
    logic [3:0]       rd;
    logic [3:0]       rs;
    logic [3:0]       rt;
    logic             need_a;
    logic             need_b;
    logic             wr_en;
    logic             hit_a;
    logic             hit_b;
    logic             pop;
    dec_op_t          nxt_op;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    //////////////////////////////////////////////////
    // Field split of the head entry
    //////////////////////////////////////////////////
    assign head = queue[rd_ptr];
    assign rd   = head.instr[11:8];
    assign rs   = head.instr[7:4];
    assign rt   = head.instr[3:0];

    always_comb begin
        case (head.instr[15:12])
            OP_ADD, OP_SUB, OP_AND, OP_NOR, OP_SLL, OP_SRL, OP_SRA,
            OP_ADDI, OP_LHB, OP_LLB, OP_BR: op = opcode_e'(head.instr[15:12]);
            default:                        op = OP_NOP;      // Unknown code
        endcase
    end

    // Which read ports the op really uses
    always_comb begin
        need_a = 1'b0;
        need_b = 1'b0;
        wr_en  = 1'b1;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_NOR: begin
                need_a = 1'b1;
                need_b = 1'b1;
            end
            OP_SLL, OP_SRL, OP_SRA, OP_ADDI: need_a = 1'b1;
            OP_LHB, OP_LLB: need_b = 1'b1;               // Old rd value
            default: wr_en = 1'b0;                       // BR, NOP
        endcase
    end

    assign rd_addr_a = rs;
    assign rd_addr_b = (op == OP_LHB || op == OP_LLB) ? rd : rt;

    //////////////////////////////////////////////////
    // Scoreboard against execute input and output
    //////////////////////////////////////////////////
    assign hit_a = need_a && rd_addr_a != 4'd0 &&
                   ((dec_op.valid && dec_op.wr_en && dec_op.dest == rd_addr_a) ||
                    (ex_wr && ex_dest == rd_addr_a));
    assign hit_b = need_b && rd_addr_b != 4'd0 &&
                   ((dec_op.valid && dec_op.wr_en && dec_op.dest == rd_addr_b) ||
                    (ex_wr && ex_dest == rd_addr_b));

    assign pop = (count != '0) && !hit_a && !hit_b;  // Else a bubble goes out

    always_comb begin
        nxt_op          = '0;
        nxt_op.valid    = pop;
        nxt_op.op       = op;
        nxt_op.cond     = branch_cond_e'(head.instr[11:9]);
        nxt_op.dest     = rd;
        nxt_op.wr_en    = wr_en;
        nxt_op.src_a    = rd_data_a;
        nxt_op.src_b    = rd_data_b;
        nxt_op.use_imm  = (op == OP_ADDI);
        nxt_op.half_imm = head.instr[7:0];
        nxt_op.pc       = head.pc;
        if (op == OP_BR)
            nxt_op.imm = {{7{head.instr[8]}}, head.instr[8:0]};   // 9-bit offset
        else
            nxt_op.imm = {{12{head.instr[3]}}, head.instr[3:0]};
    end

    // Queue storage, space guaranteed by credits
    always_ff @(posedge clk) begin
        if (in_valid)
            queue[wr_ptr] <= in_word;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (in_valid)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit_return <= pop;                // One credit per freed slot
        end
    end

    always_ff @(posedge clk) begin
        dec_op <= nxt_op;
        if (rst)
            dec_op.valid <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== design/result_stage.sv ====
// Result stage: register file, writeback and the retire record
`timescale 1ns/100ps
`default_nettype none

module result_stage (
    input  wire                         clk,
    input  wire                         rst,
    input  wire exec_core_pkg::ex_res_t ex_res,
    input  wire [15:0]                  pc_in,
    input  wire [3:0]                   rd_addr_a,
    input  wire [3:0]                   rd_addr_b,
    output logic [15:0]                 rd_data_a,
    output logic [15:0]                 rd_data_b,
    output logic                        retire_valid,
    output exec_core_pkg::retire_t      retire
);
    import exec_core_pkg::*;

    logic [REG_W-1:0] regs [REG_CNT];
    logic [15:0]      pc_q;                 // pc of the op now in ex_res

    //////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_CNT; i++)
                regs[i] <= '0;
        end else if (ex_res.valid && ex_res.wr_en && ex_res.dest != 4'd0) begin
            regs[ex_res.dest] <= ex_res.data;   // r0 stays zero
        end
    end

    // Async reads, decode stalls instead of bypass
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    //////////////////////////////////////////////////
    // Retire record
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst)
            retire_valid <= 1'b0;
        else
            retire_valid <= ex_res.valid;
    end

    // pc_in trails ex_res by one stage, realign here
    always_ff @(posedge clk) begin
        pc_q         <= pc_in;
        retire.dest  <= ex_res.dest;
        retire.data  <= ex_res.data;
        retire.wr_en <= ex_res.wr_en;
        retire.pc    <= pc_q;
    end

endmodule

`default_nettype wire

// ==== exec_core.f ====
design/exec_core_pkg.sv
design/alu16.sv
design/flag_branch_unit.sv
design/ex_unit.sv
design/instr_decode.sv
design/result_stage.sv
design/exec_core.sv
verif/tb_clk_gen.sv
verif/exec_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile the execute core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module exec_core_tb -f exec_core.f -o exec_core_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! sim_out=$(./obj_dir/exec_core_sim); then
    echo "$sim_out"
    echo "simulation exited with an error status"
    exit 1
fi
echo "$sim_out"

# Verdict comes from the testbench's own closing line
if echo "$sim_out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

// ==== verif/exec_core_tb.sv ====
// Execute core testbench with LFSR stimulus, credit source, reference model, checks and report
`timescale 1ns/100ps
`default_nettype none

module exec_core_tb;
    import exec_core_pkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int STALL_LIMIT = 200;       // Cycles without a send
    localparam int DRAIN_LIMIT = 400;       // Cycles to empty the pipe
    localparam int MODE_ALU    = 0;
    localparam int MODE_HALF   = 1;
    localparam int MODE_BRANCH = 2;
    localparam int MODE_MIX    = 3;
    localparam int MODE_ZERO   = 4;

    logic        clk;
    logic        rst;
    logic        in_valid;
    fetch_word_t in_word;
    logic        credit_return;
    logic        retire_valid;
    retire_t     retire;
    logic        redirect_valid;
    redirect_t   redirect;

    // Reference model state
    logic [15:0] mregs [16];
    flags_t      mflags;
    retire_t     exp_retire_q [$];
    logic        exp_br_q [$];              // Marks branches in retire order
    redirect_t   exp_redirect_q [$];

    logic [15:0] lfsr;
    logic [15:0] pc_next;
    int          credits;                   // Source side credit count
    logic        redir_prev;
    logic        hung;
    string       test_name;
    int          test_errs;
    int          test_sent;
    int          test_returns;
    int          test_retired;
    int          tests_run;
    int          tests_failed;
    int          sent_total;

    tb_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    exec_core #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_exec_core (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_word        (in_word),
        .credit_return  (credit_return),
        .retire_valid   (retire_valid),
        .retire         (retire),
        .redirect_valid (redirect_valid),
        .redirect       (redirect)
    );

    //////////////////////////////////////////////////
    // Random bits and instruction builder
    //////////////////////////////////////////////////
    // Taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);         // One step per bit
            bits = {bits[14:0], lfsr[0]};
        end
        return bits;
    endfunction

    function automatic logic [15:0] make_instr(input int mode, input int idx);
        logic [3:0] alu_op;
        logic [2:0] kind;
        logic [3:0] rd;
        logic [3:0] rs;
        logic [3:0] rt;
        alu_op = 4'(take_bits(3));          // Codes 0..7 are the ALU ops
        kind   = 3'(take_bits(3));
        rd     = 4'(take_bits(4));
        rs     = 4'(take_bits(4));
        rt     = 4'(take_bits(4));
        case (mode)
            MODE_HALF: begin
                rd = {2'b00, rd[1:0]};      // Few registers, many back to back hits
                rs = {2'b00, rs[1:0]};
                rt = {2'b00, rt[1:0]};
                if (kind[1:0] != 2'b00)
                    return {kind[2] ? OP_LHB : OP_LLB, rd, rs, rt};
            end
            MODE_BRANCH: begin
                if (idx % 3 == 1)
                    return {kind[2] ? OP_LHB : OP_LLB, rd, rs, rt};  // Flags must survive
                if (idx % 3 == 2)
                    return {OP_BR, 3'(idx / 3), rd[0], rs, rt};       // Walk all conditions
            end
            MODE_MIX: begin
                if (kind == 3'd5)
                    return {alu_op[0] ? OP_LHB : OP_LLB, rd, rs, rt};
                if (kind == 3'd6)
                    return {OP_BR, rd, rs, rt};
                if (kind == 3'd7)
                    return {OP_NOP, rd, rs, rt};
            end
            MODE_ZERO: begin
                if (kind[0]) rd = 4'd0;     // Writes into r0
                if (kind[1]) rs = 4'd0;
                if (kind[2]) rt = 4'd0;
            end
            default: ;
        endcase
        return {alu_op, rd, rs, rt};
    endfunction

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////
    task automatic model_execute(input fetch_word_t w);
        logic [3:0]  code;
        logic [3:0]  rd;
        logic [3:0]  rs;
        logic [3:0]  rt;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] imm;
        logic [15:0] off;
        logic [15:0] res;
        int          sa;
        int          s;
        logic        wr;
        logic        v;
        logic        taken;
        logic        is_br;
        retire_t     want;
        redirect_t   rwant;
        code  = w.instr[15:12];
        rd    = w.instr[11:8];
        rs    = w.instr[7:4];
        rt    = w.instr[3:0];
        a     = mregs[rs];
        b     = mregs[rt];
        imm   = {{12{rt[3]}}, rt};
        sa    = int'($signed(a));
        res   = '0;
        v     = 1'b0;
        wr    = 1'b1;
        is_br = 1'b0;
        case (code)
            OP_ADD, OP_ADDI: begin
                s   = sa + ((code == OP_ADDI) ? int'($signed(imm)) : int'($signed(b)));
                res = 16'(s);
                v   = (s > 32767) || (s < -32768);   // Outside the 16-bit signed range
            end
            OP_SUB: begin
                s   = sa - int'($signed(b));
                res = 16'(s);
                v   = (s > 32767) || (s < -32768);
            end
            OP_AND: res = a & b;
            OP_NOR: res = ~(a | b);
            OP_SLL: res = a << rt;
            OP_SRL: res = a >> rt;
            OP_SRA: res = 16'(sa >>> rt);
            OP_LHB: res = {w.instr[7:0], mregs[rd][7:0]};
            OP_LLB: res = {mregs[rd][15:8], w.instr[7:0]};
            OP_BR: begin
                wr    = 1'b0;
                is_br = 1'b1;
                off   = {{7{w.instr[8]}}, w.instr[8:0]};
                case (w.instr[11:9])
                    BC_NE:   taken = !mflags.z;
                    BC_EQ:   taken = mflags.z;
                    BC_GT:   taken = !mflags.z && !mflags.n;
                    BC_LT:   taken = mflags.n;
                    BC_GE:   taken = !mflags.n;
                    BC_LE:   taken = mflags.z || mflags.n;
                    BC_OV:   taken = mflags.v;
                    default: taken = 1'b1;
                endcase
                rwant.taken  = taken;
                rwant.target = w.pc + 16'd1 + off;
                exp_redirect_q.push_back(rwant);
            end
            default: wr = 1'b0;             // NOP and unknown codes
        endcase
        if (code <= 4'h7) begin             // Only ALU ops move the flags
            mflags.z = (res == 16'd0);
            mflags.n = res[15];
            mflags.v = v;
        end
        if (wr && rd != 4'd0)
            mregs[rd] = res;
        want.dest  = rd;
        want.data  = res;
        want.wr_en = wr;
        want.pc    = w.pc;
        exp_retire_q.push_back(want);
        exp_br_q.push_back(is_br);
    endtask

    //////////////////////////////////////////////////
    // Checking and bookkeeping
    //////////////////////////////////////////////////
    task automatic note_mismatch(input string what, input logic [63:0] want,
                                 input logic [63:0] got);
        $display("error %s %s: expected %0h, actual %0h", test_name, what, want, got);
        test_errs++;
    endtask

    task automatic note_failure(input string why);
        $display("failure in %s: %s", test_name, why);
        test_errs++;
    endtask

    // One clock, then sample outputs that settled over the last cycle
    task automatic tick();
        retire_t   want;
        redirect_t rwant;
        logic      was_br;
        @(posedge clk);
        if (credit_return) begin
            credits++;
            test_returns++;
        end
        assert (credits >= 0 && credits <= QUEUE_DEPTH)
            else note_failure("source credit count left the range 0 to the queue depth");
        if (redirect_valid) begin
            assert (exp_redirect_q.size() != 0)
                else note_failure("redirect reported with no branch outstanding");
            if (exp_redirect_q.size() != 0) begin
                rwant = exp_redirect_q.pop_front();
                assert (redirect == rwant)
                    else note_mismatch("redirect", 64'(rwant), 64'(redirect));
            end
        end
        if (retire_valid) begin
            test_retired++;
            assert (exp_retire_q.size() != 0)
                else note_failure("an instruction retired that was never sent");
            if (exp_retire_q.size() != 0) begin
                want   = exp_retire_q.pop_front();
                was_br = exp_br_q.pop_front();
                assert (retire == want)
                    else note_mismatch("retire", 64'(want), 64'(retire));
                assert (!was_br || redir_prev)
                    else note_failure("branch retired without a redirect one cycle before");
            end
        end
        redir_prev = redirect_valid;
    endtask

    // Credit respecting source, then wait for the pipe to empty
    task automatic run_stream(input int mode, input int count, input int gap_bits);
        fetch_word_t w;
        int          idle;
        idle = 0;
        while (test_sent < count && !hung) begin
            tick();
            if (credits > 0 && take_bits(gap_bits) != 0) begin
                w.pc    = pc_next;
                w.instr = make_instr(mode, test_sent);
                model_execute(w);
                in_valid <= 1'b1;
                in_word  <= w;
                pc_next  = pc_next + 16'd1;
                credits--;                  // Spent on this send
                test_sent++;
                idle = 0;
            end else begin
                in_valid <= 1'b0;
                idle++;
                if (idle > STALL_LIMIT) begin
                    note_failure("timed out waiting for a credit to send the next instruction");
                    hung = 1'b1;
                end
            end
        end
        tick();
        in_valid <= 1'b0;
        idle = 0;
        while (!hung && (exp_retire_q.size() != 0 || credits != QUEUE_DEPTH)) begin
            tick();
            idle++;
            if (idle > DRAIN_LIMIT) begin
                note_failure("timed out waiting for the pipeline to drain");
                hung = 1'b1;
            end
        end
    endtask

    task automatic begin_test(input string name);
        test_name    = name;
        test_errs    = 0;
        test_sent    = 0;
        test_returns = 0;
        test_retired = 0;
    endtask

    task automatic end_test();
        if (!hung) begin
            assert (credits == QUEUE_DEPTH)
                else note_mismatch("credits after drain", 64'(QUEUE_DEPTH), 64'(credits));
            assert (test_returns == test_sent)
                else note_mismatch("credit returns", 64'(test_sent), 64'(test_returns));
            assert (test_retired == test_sent)
                else note_mismatch("retired count", 64'(test_sent), 64'(test_retired));
            assert (exp_redirect_q.size() == 0)
                else note_failure("a branch never reported its redirect");
        end
        tests_run++;
        sent_total += test_sent;
        if (test_errs != 0)
            tests_failed++;
        $display("test %-12s %s  sent %0d  retired %0d  errors %0d", test_name,
                 (test_errs == 0) ? "passed" : "failed", test_sent, test_retired, test_errs);
    endtask

    task automatic run_test(input string name, input int mode, input int count,
                            input int gap_bits);
        if (hung)
            return;
        begin_test(name);
        run_stream(mode, count, gap_bits);
        end_test();
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin
        int waited;
        in_valid     <= 1'b0;
        in_word      <= '0;
        lfsr         = 16'd8;               // Seed
        pc_next      = 16'h0100;
        credits      = QUEUE_DEPTH;
        redir_prev   = 1'b0;
        hung         = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        sent_total   = 0;
        mflags       = '0;
        for (int r = 0; r < 16; r++)
            mregs[r] = '0;

        // Outputs stay quiet through and after reset with no input
        begin_test("reset_idle");
        waited = 0;
        do begin
            tick();                         // rst settles on the first edge
            waited++;
        end while (rst && waited < 20);
        if (rst) begin
            note_failure("reset was never released");
            hung = 1'b1;
        end
        for (int i = 0; i < 12 && !hung; i++) begin
            tick();
            assert ({retire_valid, redirect_valid, credit_return} == 3'b000)
                else note_mismatch("idle outputs", 64'd0,
                                   64'({retire_valid, redirect_valid, credit_return}));
        end
        end_test();

        run_test("alu_ops",     MODE_ALU,    48, 1);
        run_test("load_half",   MODE_HALF,   48, 1);
        run_test("branch_cond", MODE_BRANCH, 48, 1);
        run_test("credit_flow", MODE_MIX,    96, 3);    // Mostly full rate
        run_test("reg_zero",    MODE_ZERO,   40, 1);

        $display("summary: %0d tests run, %0d passed, %0d failed, %0d instructions sent",
                 tests_run, tests_run - tests_failed, tests_failed, sent_total);
        if (tests_failed == 0 && !hung)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
// Testbench clock and synchronous reset generator
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
    parameter int HALF_PERIOD  = 2,         // 4 ns clock
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Held high over the first rising edges, dropped right after one
    initial begin
        rst <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire
